/* logic/arcade_input_config.svh */
//====================
// Build-time settings for the player-input block
// Event FIFO depth and PS/2 clock filter length
//====================

`ifndef ARCADE_INPUT_CONFIG_SVH
`define ARCADE_INPUT_CONFIG_SVH

// ====================
// Event queue
// ====================

// Number of key events held between the decoder and the mapper
`define ARC_EVT_FIFO_DEPTH 8

// ====================
// PS/2 line filter
// ====================

// Equal samples of the PS/2 clock needed before an edge counts
`define ARC_PS2_FILTER_LEN 4

`endif

/* logic/arcade_input_pkg.sv */
//====================
// Shared types for the player-input block
// Key action, decoder frame state, control bus index, scan code
//====================

package arcade_input_pkg;

	// A PS/2 make code as it appears on the wire
	typedef logic [7:0] scan_code_t;

	// Whether a key went down or came back up
	typedef enum logic {
		key_press   = 1'b0,
		key_release = 1'b1
	} key_action_e;

	// Frame receiver states of the PS/2 decoder
	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_data   = 2'd1,
		st_parity = 2'd2,
		st_stop   = 2'd3
	} ps2_state_e;

	// Bit position of each player function on the control bus and the joystick ports
	typedef enum logic [2:0] {
		ctrl_fire   = 3'd0,
		ctrl_start1 = 3'd1,
		ctrl_start2 = 3'd2,
		ctrl_coin   = 3'd3,
		ctrl_up     = 3'd4,
		ctrl_down   = 3'd5,
		ctrl_left   = 3'd6,
		ctrl_right  = 3'd7
	} ctrl_bit_e;

endpackage

/* logic/ps2_key_decoder.sv */
//====================
// PS/2 keyboard decoder
// Line synchronisers, clock filter, frame FSM, E0/F0 prefixes, event output
//====================

`include "arcade_input_config.svh"

module ps2_key_decoder (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  logic                          ps2_clk_i,
	input  logic                          ps2_data_i,
	output logic                          evt_valid_o,
	input  logic                          evt_ready_i,
	output arcade_input_pkg::scan_code_t  evt_code_o,
	output logic                          evt_ext_o,
	output arcade_input_pkg::key_action_e evt_action_o,
	output logic                          overrun_o,
	output logic                          frame_err_o
);

	localparam int FILT_LEN = `ARC_PS2_FILTER_LEN;
	localparam int FILT_W = $clog2(FILT_LEN + 1);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_filt;
	logic [FILT_W-1:0] filt_cnt;
	logic filt_flip;
	logic clk_fall;

	arcade_input_pkg::ps2_state_e state;
	logic [2:0] bit_cnt;
	arcade_input_pkg::scan_code_t shift_reg;
	logic parity_ok;
	logic ext_flag;
	logic rel_flag;

	logic byte_done;
	logic frame_ok;
	logic is_prefix;
	logic evt_held;
	logic evt_load;

	// ====================
	// Input conditioning
	// ====================

	// Both lines idle high, so the synchronisers come out of reset that way
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk_i};
			data_sync <= {data_sync[0], ps2_data_i};
		end
	end

	// The filtered clock only follows after FILT_LEN samples in a row disagree with it
	assign filt_flip = (clk_sync[1] != clk_filt) && (filt_cnt == FILT_W'(FILT_LEN - 1));
	assign clk_fall  = filt_flip && clk_filt;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			clk_filt <= 1'b1;
			filt_cnt <= '0;
		end else if (clk_sync[1] == clk_filt) begin
			filt_cnt <= '0;
		end else if (filt_flip) begin
			clk_filt <= clk_sync[1];
			filt_cnt <= '0;
		end else begin
			filt_cnt <= filt_cnt + 1'b1;
		end
	end

	// ====================
	// Frame receiver
	// ====================

	assign byte_done = clk_fall && (state == arcade_input_pkg::st_stop);
	assign frame_ok  = data_sync[1] && parity_ok;
	assign is_prefix = (shift_reg == 8'hE0) || (shift_reg == 8'hF0);
	assign evt_held  = evt_valid_o && !evt_ready_i;
	assign evt_load  = byte_done && frame_ok && !is_prefix && !evt_held;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state       <= arcade_input_pkg::st_idle;
			bit_cnt     <= '0;
			parity_ok   <= 1'b0;
			ext_flag    <= 1'b0;
			rel_flag    <= 1'b0;
			evt_valid_o <= 1'b0;
			overrun_o   <= 1'b0;
			frame_err_o <= 1'b0;
		end else begin
			if (evt_valid_o && evt_ready_i)
				evt_valid_o <= 1'b0;
			if (clk_fall) begin
				case (state)
					arcade_input_pkg::st_idle: begin
						if (!data_sync[1]) begin
							state   <= arcade_input_pkg::st_data;
							bit_cnt <= '0;
						end else begin
							// A high start bit means we lost frame alignment
							frame_err_o <= 1'b1;
							ext_flag    <= 1'b0;
							rel_flag    <= 1'b0;
						end
					end
					arcade_input_pkg::st_data: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= arcade_input_pkg::st_parity;
					end
					arcade_input_pkg::st_parity: begin
						// Odd parity over the data byte and the parity bit
						parity_ok <= (^shift_reg) ^ data_sync[1];
						state     <= arcade_input_pkg::st_stop;
					end
					default: begin
						state <= arcade_input_pkg::st_idle;
						if (!frame_ok) begin
							frame_err_o <= 1'b1;
							ext_flag    <= 1'b0;
							rel_flag    <= 1'b0;
						end else if (shift_reg == 8'hE0) begin
							ext_flag <= 1'b1;
						end else if (shift_reg == 8'hF0) begin
							rel_flag <= 1'b1;
						end else begin
							// The previous event is still waiting, so this one is lost
							if (evt_held)
								overrun_o <= 1'b1;
							else
								evt_valid_o <= 1'b1;
							ext_flag <= 1'b0;
							rel_flag <= 1'b0;
						end
					end
				endcase
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk_sys) begin
		if (clk_fall && (state == arcade_input_pkg::st_data))
			shift_reg <= {data_sync[1], shift_reg[7:1]};
		if (evt_load) begin
			evt_code_o   <= shift_reg;
			evt_ext_o    <= ext_flag;
			evt_action_o <= rel_flag ? arcade_input_pkg::key_release
			                         : arcade_input_pkg::key_press;
		end
	end

endmodule

/* logic/key_event_fifo.sv */
//====================
// Synchronous FIFO for key events
// Circular buffer with occupancy count, valid/ready on both sides
//====================

`include "arcade_input_config.svh"

module key_event_fifo #(
	parameter int DEPTH = `ARC_EVT_FIFO_DEPTH
) (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  logic                          in_valid_i,
	output logic                          in_ready_o,
	input  arcade_input_pkg::scan_code_t  in_code_i,
	input  logic                          in_ext_i,
	input  arcade_input_pkg::key_action_e in_action_i,
	output logic                          out_valid_o,
	input  logic                          out_ready_i,
	output arcade_input_pkg::scan_code_t  out_code_o,
	output logic                          out_ext_o,
	output arcade_input_pkg::key_action_e out_action_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	arcade_input_pkg::scan_code_t  code_mem [DEPTH];
	logic                          ext_mem [DEPTH];
	arcade_input_pkg::key_action_e action_mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;

	// Pointers wrap at DEPTH so that depths other than a power of two work too
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign in_ready_o  = (count != CW'(DEPTH));
	assign out_valid_o = (count != '0);
	assign push = in_valid_i && in_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	// Head entry is read straight from the array
	assign out_code_o   = code_mem[rd_ptr];
	assign out_ext_o    = ext_mem[rd_ptr];
	assign out_action_o = action_mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (push) begin
			code_mem[wr_ptr]   <= in_code_i;
			ext_mem[wr_ptr]    <= in_ext_i;
			action_mem[wr_ptr] <= in_action_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			// Push and pop together leave the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* logic/control_mapper.sv */
//====================
// Player control mapper
// Key-held state, joystick merge, upright rotation, active-low control bus
//====================

module control_mapper (
	input  logic                          clk_sys,
	input  logic                          rst_i,
	input  logic                          evt_valid_i,
	output logic                          evt_ready_o,
	input  arcade_input_pkg::scan_code_t  evt_code_i,
	input  logic                          evt_ext_i,
	input  arcade_input_pkg::key_action_e evt_action_i,
	input  logic [7:0]                    joy0_i,
	input  logic [7:0]                    joy1_i,
	input  logic                          upright_i,
	output logic [7:0]                    ctrl_n_o
);

	arcade_input_pkg::ctrl_bit_e fn_idx;
	logic fn_hit;
	logic [7:0] held;
	logic [7:0] raw;
	logic [7:0] mapped;

	// One event per cycle is always enough, so the mapper never stalls
	assign evt_ready_o = 1'b1;

	// ====================
	// Key table
	// ====================

	always_comb begin
		fn_hit = 1'b1;
		fn_idx = arcade_input_pkg::ctrl_fire;
		if (evt_ext_i) begin
			// Arrow keys come with the E0 prefix
			case (evt_code_i)
				8'h75:   fn_idx = arcade_input_pkg::ctrl_up;
				8'h72:   fn_idx = arcade_input_pkg::ctrl_down;
				8'h6B:   fn_idx = arcade_input_pkg::ctrl_left;
				8'h74:   fn_idx = arcade_input_pkg::ctrl_right;
				default: fn_hit = 1'b0;
			endcase
		end else begin
			case (evt_code_i)
				8'h29:   fn_idx = arcade_input_pkg::ctrl_fire;
				8'h16:   fn_idx = arcade_input_pkg::ctrl_start1;
				8'h1E:   fn_idx = arcade_input_pkg::ctrl_start2;
				8'h2E:   fn_idx = arcade_input_pkg::ctrl_coin;
				default: fn_hit = 1'b0;
			endcase
		end
	end

	// Press sets the function, release clears it
	always_ff @(posedge clk_sys) begin
		if (rst_i)
			held <= '0;
		else if (evt_valid_i && evt_ready_o && fn_hit)
			held[fn_idx] <= (evt_action_i == arcade_input_pkg::key_press);
	end

	// ====================
	// Merge and rotation
	// ====================

	assign raw = held | joy0_i | joy1_i;

	// Upright cabinets turn the stick a quarter turn
	always_comb begin
		mapped = raw;
		if (upright_i) begin
			mapped[arcade_input_pkg::ctrl_up]    = raw[arcade_input_pkg::ctrl_left];
			mapped[arcade_input_pkg::ctrl_down]  = raw[arcade_input_pkg::ctrl_right];
			mapped[arcade_input_pkg::ctrl_left]  = raw[arcade_input_pkg::ctrl_down];
			mapped[arcade_input_pkg::ctrl_right] = raw[arcade_input_pkg::ctrl_up];
		end
	end

	// The game core wants a low level for an active control
	always_ff @(posedge clk_sys) begin
		if (rst_i)
			ctrl_n_o <= '1;
		else
			ctrl_n_o <= ~mapped;
	end

endmodule

/* logic/arcade_input_top.sv */
//====================
// Player-input block top level
// PS/2 decoder feeding the event FIFO feeding the control mapper
//====================

`include "arcade_input_config.svh"

module arcade_input_top (
	input  logic       clk_sys,
	input  logic       rst_i,
	input  logic       ps2_clk_i,
	input  logic       ps2_data_i,
	input  logic [7:0] joy0_i,
	input  logic [7:0] joy1_i,
	input  logic       upright_i,
	output logic [7:0] ctrl_n_o,
	output logic       overrun_o,
	output logic       frame_err_o
);

	// Decoder to FIFO
	logic                          evt_valid;
	logic                          evt_ready;
	arcade_input_pkg::scan_code_t  evt_code;
	logic                          evt_ext;
	arcade_input_pkg::key_action_e evt_action;

	// FIFO to mapper
	logic                          q_valid;
	logic                          q_ready;
	arcade_input_pkg::scan_code_t  q_code;
	logic                          q_ext;
	arcade_input_pkg::key_action_e q_action;

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys      (clk_sys),
		.rst_i        (rst_i),
		.ps2_clk_i    (ps2_clk_i),
		.ps2_data_i   (ps2_data_i),
		.evt_valid_o  (evt_valid),
		.evt_ready_i  (evt_ready),
		.evt_code_o   (evt_code),
		.evt_ext_o    (evt_ext),
		.evt_action_o (evt_action),
		.overrun_o    (overrun_o),
		.frame_err_o  (frame_err_o)
	);

	key_event_fifo #(
		.DEPTH (`ARC_EVT_FIFO_DEPTH)
	) u_key_event_fifo (
		.clk_sys      (clk_sys),
		.rst_i        (rst_i),
		.in_valid_i   (evt_valid),
		.in_ready_o   (evt_ready),
		.in_code_i    (evt_code),
		.in_ext_i     (evt_ext),
		.in_action_i  (evt_action),
		.out_valid_o  (q_valid),
		.out_ready_i  (q_ready),
		.out_code_o   (q_code),
		.out_ext_o    (q_ext),
		.out_action_o (q_action)
	);

	control_mapper u_control_mapper (
		.clk_sys      (clk_sys),
		.rst_i        (rst_i),
		.evt_valid_i  (q_valid),
		.evt_ready_o  (q_ready),
		.evt_code_i   (q_code),
		.evt_ext_i    (q_ext),
		.evt_action_i (q_action),
		.joy0_i       (joy0_i),
		.joy1_i       (joy1_i),
		.upright_i    (upright_i),
		.ctrl_n_o     (ctrl_n_o)
	);

endmodule

/* tb/tb_clock_gen.sv */
//====================
// Testbench clock and reset source
// Free-running clock, synchronous reset held for a fixed number of cycles
//====================

module tb_clock_gen #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// Release lands just after an edge, like every other driven input
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#2;
		rst_o = 1'b0;
	end

endmodule

/* tb/input_checker.sv */
//====================
// Result checker for the player-input testbench
// Compares the control bus and status flags on request, keeps the counts
//====================

module input_checker #(
	parameter int NAME_W = 256
) (
	input  logic              clk_i,
	input  logic              check_i,
	input  logic              done_i,
	input  logic [NAME_W-1:0] name_i,
	input  logic [7:0]        exp_ctrl_n_i,
	input  logic              exp_overrun_i,
	input  logic              exp_frame_err_i,
	input  logic [7:0]        ctrl_n_i,
	input  logic              overrun_i,
	input  logic              frame_err_i,
	output int                pass_cnt_o,
	output int                fail_cnt_o
);

	logic [7:0] bus_diff;

	// Names the lowest control function whose level is wrong
	function automatic string first_wrong_function(input logic [7:0] diff);
		arcade_input_pkg::ctrl_bit_e idx;
		int i;
		for (i = 0; i < 8; i++) begin
			if (diff[i]) begin
				idx = arcade_input_pkg::ctrl_bit_e'(i[2:0]);
				return idx.name();
			end
		end
		return "none";
	endfunction

	initial begin
		pass_cnt_o = 0;
		fail_cnt_o = 0;
	end

	// Sampling on the falling edge keeps clear of the DUT's register updates
	always @(negedge clk_i) begin
		if (check_i) begin
			bus_diff = ctrl_n_i ^ exp_ctrl_n_i;
			if ((ctrl_n_i !== exp_ctrl_n_i) || (overrun_i !== exp_overrun_i)
					|| (frame_err_i !== exp_frame_err_i)) begin
				fail_cnt_o = fail_cnt_o + 1;
				$write("** Error %0s: expected ctrl_n=%h overrun=%b frame_err=%b, ",
					name_i, exp_ctrl_n_i, exp_overrun_i, exp_frame_err_i);
				$display("actual ctrl_n=%h overrun=%b frame_err=%b, first bad function %0s",
					ctrl_n_i, overrun_i, frame_err_i, first_wrong_function(bus_diff));
			end else begin
				pass_cnt_o = pass_cnt_o + 1;
				$display("PASS %0s: ctrl_n=%h overrun=%b frame_err=%b",
					name_i, ctrl_n_i, overrun_i, frame_err_i);
			end
		end
		if (done_i)
			$display("Tests run: %0d, passed: %0d, failed: %0d",
				pass_cnt_o + fail_cnt_o, pass_cnt_o, fail_cnt_o);
	end

endmodule

/* tb/arcade_input_tb.sv */
//====================
// Testbench top for the player-input block
// Reads the vector file, sends PS/2 frames, drives joysticks and upright
// Instantiates clock source, DUT and checker, watches for a timeout
//====================

`include "arcade_input_config.svh"

module arcade_input_tb;

	localparam int BIT_PERIOD = 8 * `ARC_PS2_FILTER_LEN;
	localparam int HALF_BIT = BIT_PERIOD / 2;
	localparam int SETTLE_CYCLES = `ARC_EVT_FIFO_DEPTH + 8;
	localparam int NAME_W = 256;
	localparam string VEC_FILE = "tb/arcade_input_vectors_input.txt";

	logic clk_sys;
	logic rst;
	logic ps2_clk;
	logic ps2_data;
	logic [7:0] joy0;
	logic [7:0] joy1;
	logic upright;
	logic [7:0] ctrl_n;
	logic overrun;
	logic frame_err;

	logic check_req;
	logic run_done;
	logic [NAME_W-1:0] chk_name;
	logic [7:0] exp_ctrl_n;
	logic exp_overrun;
	logic exp_frame_err;
	int pass_cnt;
	int fail_cnt;

	// Per-test fields sit in parallel queues and all bytes share one flat queue
	string t_name[$];
	logic [7:0] t_joy0[$];
	logic [7:0] t_joy1[$];
	logic t_upright[$];
	logic [7:0] t_exp_ctrl[$];
	logic t_exp_ovr[$];
	logic t_exp_ferr[$];
	int t_first[$];
	int t_count[$];
	logic [8:0] byte_q[$];

	int cycle_limit;
	int cycle_cnt;

	tb_clock_gen #(
		.PERIOD     (40),
		.RST_CYCLES (8)
	) u_tb_clock_gen (
		.clk_o (clk_sys),
		.rst_o (rst)
	);

	arcade_input_top u_arcade_input_top (
		.clk_sys     (clk_sys),
		.rst_i       (rst),
		.ps2_clk_i   (ps2_clk),
		.ps2_data_i  (ps2_data),
		.joy0_i      (joy0),
		.joy1_i      (joy1),
		.upright_i   (upright),
		.ctrl_n_o    (ctrl_n),
		.overrun_o   (overrun),
		.frame_err_o (frame_err)
	);

	input_checker #(
		.NAME_W (NAME_W)
	) u_input_checker (
		.clk_i           (clk_sys),
		.check_i         (check_req),
		.done_i          (run_done),
		.name_i          (chk_name),
		.exp_ctrl_n_i    (exp_ctrl_n),
		.exp_overrun_i   (exp_overrun),
		.exp_frame_err_i (exp_frame_err),
		.ctrl_n_i        (ctrl_n),
		.overrun_i       (overrun),
		.frame_err_i     (frame_err),
		.pass_cnt_o      (pass_cnt),
		.fail_cnt_o      (fail_cnt)
	);

	// ====================
	// Helpers
	// ====================

	function automatic logic [NAME_W-1:0] name_to_vec(input string s);
		logic [NAME_W-1:0] v;
		int i;
		v = '0;
		for (i = 0; (i < s.len()) && (i < NAME_W / 8); i++)
			v = {v[NAME_W-9:0], s.getc(i)};
		return v;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#2;
	endtask

	// The device changes data while its clock is high and the host samples on the fall
	task automatic send_bit(input logic b);
		ps2_data = b;
		wait_cycles(HALF_BIT);
		ps2_clk = 1'b0;
		wait_cycles(HALF_BIT);
		ps2_clk = 1'b1;
	endtask

	// Bit 8 of the entry asks for a wrong parity bit
	task automatic send_byte(input logic [8:0] entry);
		logic [10:0] frame;
		logic par;
		int i;
		par = ~(^entry[7:0]) ^ entry[8];
		frame = {1'b1, par, entry[7:0], 1'b0};
		for (i = 0; i < 11; i++)
			send_bit(frame[i]);
		wait_cycles(BIT_PERIOD);
	endtask

	task automatic load_vectors(output logic ok);
		int fd;
		int rc;
		int c;
		int n;
		int k;
		string tok;
		logic [7:0] j0;
		logic [7:0] j1;
		logic up;
		logic [7:0] ec;
		logic eo;
		logic ef;
		logic [8:0] b;
		ok = 1'b1;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the vector file %s", VEC_FILE);
			ok = 1'b0;
			return;
		end
		while (ok) begin
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1)
				break;
			if (tok.getc(0) == "#") begin
				// Skip the rest of a comment line
				c = 0;
				while ((c != 10) && (c != -1))
					c = $fgetc(fd);
				continue;
			end
			rc = $fscanf(fd, "%h %h %h %h %h %h %d", j0, j1, up, ec, eo, ef, n);
			if (rc != 7) begin
				$display("Vector line for test %s is incomplete", tok);
				ok = 1'b0;
				break;
			end
			t_name.push_back(tok);
			t_joy0.push_back(j0);
			t_joy1.push_back(j1);
			t_upright.push_back(up);
			t_exp_ctrl.push_back(ec);
			t_exp_ovr.push_back(eo);
			t_exp_ferr.push_back(ef);
			t_first.push_back(byte_q.size());
			t_count.push_back(n);
			for (k = 0; k < n; k++) begin
				rc = $fscanf(fd, "%h", b);
				if (rc != 1) begin
					$display("Test %s lists fewer bytes than its count", tok);
					ok = 1'b0;
					break;
				end
				byte_q.push_back(b);
			end
		end
		$fclose(fd);
		if (ok && (t_name.size() == 0)) begin
			$display("The vector file holds no tests");
			ok = 1'b0;
		end
	endtask

	task automatic run_one_test(input int t);
		int k;
		joy0 = t_joy0[t];
		joy1 = t_joy1[t];
		upright = t_upright[t];
		for (k = t_first[t]; k < t_first[t] + t_count[t]; k++)
			send_byte(byte_q[k]);
		wait_cycles(SETTLE_CYCLES);
		chk_name = name_to_vec(t_name[t]);
		exp_ctrl_n = t_exp_ctrl[t];
		exp_overrun = t_exp_ovr[t];
		exp_frame_err = t_exp_ferr[t];
		check_req = 1'b1;
		wait_cycles(1);
		check_req = 1'b0;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		logic load_ok;
		int t;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		joy0 = '0;
		joy1 = '0;
		upright = 1'b0;
		check_req = 1'b0;
		run_done = 1'b0;
		chk_name = '0;
		exp_ctrl_n = '1;
		exp_overrun = 1'b0;
		exp_frame_err = 1'b0;
		cycle_limit = 0;
		load_vectors(load_ok);
		if (!load_ok) begin
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			cycle_limit = (byte_q.size() * 11 * BIT_PERIOD + t_name.size() * 64) * 2;
			wait (rst == 1'b0);
			wait_cycles(1);
			for (t = 0; t < t_name.size(); t++)
				run_one_test(t);
			run_done = 1'b1;
			wait_cycles(1);
			run_done = 1'b0;
			wait_cycles(1);
			if ((fail_cnt == 0) && (pass_cnt == t_name.size())) begin
				$display("SIMULATION PASSED");
			end else begin
				if (pass_cnt + fail_cnt != t_name.size())
					$display("The checker saw %0d of %0d tests",
						pass_cnt + fail_cnt, t_name.size());
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

	initial cycle_cnt = 0;

	// The limit stays at zero until the vectors are known
	always @(posedge clk_sys) begin
		if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			cycle_cnt = cycle_cnt + 1;
		end
	end

endmodule

/* tb/arcade_input_vectors_input.txt */
# name joy0 joy1 upright exp_ctrl_n exp_overrun exp_frame_err byte_count bytes...
# bytes are hex scan codes, a leading 1 (as in 129) sends that byte with bad parity
reset_idle            00 00 0 FF 0 0 0
fire_press            00 00 0 FE 0 0 1 29
fire_release          00 00 0 FF 0 0 2 F0 29
start_coin_press      00 00 0 F1 0 0 3 16 1E 2E
start_coin_release    00 00 0 FF 0 0 6 F0 16 F0 1E F0 2E
unmapped_keys         00 00 0 FE 0 0 5 29 1C 23 F0 23
fire_release_again    00 00 0 FF 0 0 2 F0 29
arrow_up_press        00 00 0 EF 0 0 2 E0 75
arrow_left_right      00 00 0 2F 0 0 4 E0 6B E0 74
arrow_release         00 00 0 FF 0 0 9 E0 F0 75 E0 F0 6B E0 F0 74
plain_75_ignored      00 00 0 FF 0 0 1 75
arrow_down_press      00 00 0 DF 0 0 2 E0 72
plain_release_ignored 00 00 0 DF 0 0 2 F0 72
arrow_down_release    00 00 0 FF 0 0 3 E0 F0 72
joystick_or           01 80 0 7C 0 0 1 16
joystick_release      00 00 0 FF 0 0 2 F0 16
upright_joystick      10 20 1 3F 0 0 0
upright_keys          00 00 1 EF 0 0 2 E0 6B
upright_off           00 00 0 BF 0 0 0
bad_parity            00 00 0 FF 0 1 4 E0 F0 6B 129
bad_parity_prefix     00 00 0 FF 0 1 2 1E0 75
burst                 00 00 0 66 0 1 12 29 16 1E 2E E0 75 E0 74 F0 16 F0 1E
burst_release         00 00 0 FF 0 1 10 F0 29 F0 2E E0 F0 75 E0 F0 74

/* files.f */
+incdir+logic
logic/arcade_input_pkg.sv
logic/ps2_key_decoder.sv
logic/key_event_fifo.sv
logic/control_mapper.sv
logic/arcade_input_top.sv
tb/tb_clock_gen.sv
tb/input_checker.sv
tb/arcade_input_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the player-input testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module arcade_input_tb \
	--Mdir obj_dir -o arcade_input_sim

out=$(./obj_dir/arcade_input_sim)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi
